/* verilog/rw_gen_ctrl_pkg.sv */
/*
 * Control constants for the read/write generator
 * FIFO sizing, count width and the generator state enum
 */
package rw_gen_ctrl_pkg;

    // ----------------------------------------------------------
    // FIFO sizing
    // ----------------------------------------------------------
    // Depth must stay a power of two, pointers wrap naturally
    localparam int FIFO_DEPTH = 16;

    // Leaves room for the two kernel stages plus margin
    localparam int PROG_FULL_THRESH = 12;

    // ----------------------------------------------------------
    // Counters and states
    // ----------------------------------------------------------
    localparam int COUNT_W = 16;

    typedef logic [COUNT_W-1:0] count_t;

    typedef enum logic [1:0] {
        GEN_IDLE  = 2'd0,
        GEN_BUSY  = 2'd1,
        GEN_PAUSE = 2'd2,
        GEN_DRAIN = 2'd3
    } rw_gen_state_e;

endpackage : rw_gen_ctrl_pkg

/* verilog/rw_gen_types_pkg.sv */
/*
 * Data types for the read/write generator
 * Element, memory request and job configuration packets, opcode enum
 */
package rw_gen_types_pkg;
    import rw_gen_ctrl_pkg::*;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEQ_W  = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [SEQ_W-1:0]  seq_t;

    typedef enum logic {
        RW_OP_READ  = 1'b0,
        RW_OP_WRITE = 1'b1
    } rw_opcode_e;

    // Element as it arrives from the engine
    typedef struct packed {
        data_t data;
        seq_t  seq;
    } element_t;

    // One request towards memory
    typedef struct packed {
        rw_opcode_e opcode;
        addr_t      address;
        data_t      data;
        seq_t       seq;
    } mem_request_t;

    // Job latched on start
    typedef struct packed {
        rw_opcode_e opcode;
        addr_t      base_address;
        addr_t      stride;
        count_t     count;
        logic       wait_responses;
    } job_config_t;

endpackage : rw_gen_types_pkg

/* verilog/rw_gen_stream_if.sv */
/*
 * Valid/ready element stream between input FIFO and kernel
 */
`timescale 1ns/1ps

interface rw_gen_stream_if
    import rw_gen_types_pkg::*;
();
    // Transfer on a clock edge with valid and ready both high
    logic     valid;
    logic     ready;
    element_t element;
    // Sink flags the pop of the job's final element
    logic     last_pop;

    modport source (
        output valid,
        output element,
        input  ready,
        input  last_pop
    );

    modport sink (
        input  valid,
        input  element,
        output ready,
        output last_pop
    );

endinterface : rw_gen_stream_if

/* verilog/rw_gen_fifo.sv */
/*
 * Synchronous FIFO on a circular buffer
 * Registered occupancy count with empty, full and programmable-full flags
 */
`timescale 1ns/1ps

module rw_gen_fifo #(
    parameter int WIDTH       = 32,
    parameter int DEPTH       = 16,
    parameter int PROG_THRESH = 12
) (
    input  logic             ap_clk,
    input  logic             areset_generator,
    input  logic             push,
    input  logic [WIDTH-1:0] din,
    input  logic             pop,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    logic [WIDTH-1:0]           mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       do_push;
    logic                       do_pop;

    // Writes to a full FIFO and reads from an empty one are dropped
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    // Head entry visible whenever not empty
    assign dout = mem[rd_ptr];

    // ----------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Flags straight from the registered count
    assign empty     = (count == '0);
    assign full      = (count == ($clog2(DEPTH+1))'(DEPTH));
    assign prog_full = (count >= ($clog2(DEPTH+1))'(PROG_THRESH));

endmodule : rw_gen_fifo

/* verilog/rw_gen_kernel.sv */
/*
 * Two-stage address generation pipeline
 * Stage one pops and computes index times stride, stage two adds base
 */
`timescale 1ns/1ps

module rw_gen_kernel
    import rw_gen_ctrl_pkg::*;
    import rw_gen_types_pkg::*;
(
    input  logic          ap_clk,
    input  logic          areset_generator,
    rw_gen_stream_if.sink elem_stream,
    input  logic          pop_enable,
    input  job_config_t   job,
    output logic          accept,
    output logic          req_push,
    output mem_request_t  req_packet
);

    logic     fire;
    count_t   elem_index;
    logic     s1_valid;
    element_t s1_element;
    addr_t    s1_offset;

    // No backpressure inside, request FIFO threshold keeps room
    assign elem_stream.ready    = pop_enable;
    assign fire                 = elem_stream.valid & elem_stream.ready;
    assign elem_stream.last_pop = fire & (elem_index == job.count - 1'b1);
    assign accept               = fire;

    // Running index, back to zero after the final pop of a job
    // so it survives pauses in the middle
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            elem_index <= '0;
        end else if (elem_stream.last_pop) begin
            elem_index <= '0;
        end else if (fire) begin
            elem_index <= elem_index + 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Stage one
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= fire;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (fire) begin
            s1_element <= elem_stream.element;
            s1_offset  <= addr_t'(elem_index) * job.stride;
        end
    end

    // ----------------------------------------------------------
    // Stage two
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            req_push <= 1'b0;
        end else begin
            req_push <= s1_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (s1_valid) begin
            req_packet.opcode  <= job.opcode;
            req_packet.address <= job.base_address + s1_offset;
            req_packet.data    <= s1_element.data;
            req_packet.seq     <= s1_element.seq;
        end
    end

endmodule : rw_gen_kernel

/* verilog/rw_gen_control.sv */
/*
 * Job control for the read/write generator
 * State machine, accepted element count, outstanding responses, done
 */
`timescale 1ns/1ps

module rw_gen_control
    import rw_gen_ctrl_pkg::*;
    import rw_gen_types_pkg::*;
(
    input  logic        ap_clk,
    input  logic        areset_generator,
    input  logic        start,
    input  job_config_t cfg,
    input  logic        accept,
    input  logic        req_fire,
    input  logic        resp_valid,
    input  logic        req_prog_full,
    input  logic        req_empty,
    input  logic        in_empty,
    input  logic        kernel_idle,
    output job_config_t job,
    output logic        pop_enable,
    output logic        done
);

    rw_gen_state_e state;
    rw_gen_state_e next_state;
    count_t        accepted;
    count_t        outstanding;
    logic          all_accepted;
    logic          drained;

    assign all_accepted = (accepted == job.count);

    // Nothing left anywhere in the datapath
    assign drained = kernel_idle & req_empty & in_empty &
                     (~job.wait_responses | (outstanding == '0));

    // ----------------------------------------------------------
    // Generator FSM
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= GEN_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            GEN_IDLE: begin
                if (start) begin
                    next_state = GEN_BUSY;
                end
            end
            GEN_BUSY: begin
                if (all_accepted) begin
                    next_state = GEN_DRAIN;
                end else if (req_prog_full) begin
                    next_state = GEN_PAUSE;
                end
            end
            GEN_PAUSE: begin
                if (!req_prog_full) begin
                    next_state = GEN_BUSY;
                end
            end
            GEN_DRAIN: begin
                if (drained) begin
                    next_state = GEN_IDLE;
                end
            end
            default: next_state = GEN_IDLE;
        endcase
    end

    // Config latch, start only honoured while idle
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            job      <= '0;
            accepted <= '0;
        end else if ((state == GEN_IDLE) && start) begin
            job      <= cfg;
            accepted <= '0;
        end else if (accept) begin
            accepted <= accepted + 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Outstanding responses
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            outstanding <= '0;
        end else begin
            case ({req_fire, resp_valid})
                2'b10: outstanding <= outstanding + 1'b1;
                2'b01: begin
                    // Stray response does not wrap the counter
                    if (outstanding != '0) begin
                        outstanding <= outstanding - 1'b1;
                    end
                end
                default: outstanding <= outstanding;
            endcase
        end
    end

    assign pop_enable = (state == GEN_BUSY) & ~all_accepted;
    assign done       = (state == GEN_IDLE);

endmodule : rw_gen_control

/* verilog/rw_gen_top.sv */
/*
 * Read/write generator top level
 * Input FIFO, address kernel, request FIFO and job control on plain ports
 */
`timescale 1ns/1ps

module rw_gen_top
    import rw_gen_ctrl_pkg::*;
    import rw_gen_types_pkg::*;
(
    input  logic       ap_clk,
    input  logic       areset,
    input  logic       start,
    input  rw_opcode_e cfg_opcode,
    input  addr_t      cfg_base_address,
    input  addr_t      cfg_stride,
    input  count_t     cfg_count,
    input  logic       cfg_wait_responses,
    input  logic       in_valid,
    input  data_t      in_data,
    input  seq_t       in_seq,
    output logic       in_ready,
    output logic       req_valid,
    input  logic       req_ready,
    output rw_opcode_e req_opcode,
    output addr_t      req_address,
    output data_t      req_data,
    output seq_t       req_seq,
    input  logic       resp_valid,
    output logic       done
);

    logic         areset_generator;
    job_config_t  cfg;
    job_config_t  job;
    element_t     in_element;
    logic         in_full;
    logic         in_empty;
    logic         pop_enable;
    logic         accept;
    logic         accept_q;
    logic         kernel_idle;
    logic         req_push;
    mem_request_t req_packet;
    mem_request_t req_head;
    logic         req_empty;
    logic         req_prog_full;
    logic         req_fire;

    rw_gen_stream_if elem_stream ();

    // One registered reset for the whole generator
    always_ff @(posedge ap_clk) begin
        areset_generator <= areset;
    end

    assign cfg = '{
        opcode:         cfg_opcode,
        base_address:   cfg_base_address,
        stride:         cfg_stride,
        count:          cfg_count,
        wait_responses: cfg_wait_responses
    };

    // ----------------------------------------------------------
    // Input FIFO
    // ----------------------------------------------------------
    assign in_element        = '{data: in_data, seq: in_seq};
    assign in_ready          = ~in_full;
    assign elem_stream.valid = ~in_empty;

    rw_gen_fifo #(
        .WIDTH      ($bits(element_t)),
        .DEPTH      (FIFO_DEPTH),
        .PROG_THRESH(FIFO_DEPTH)
    ) i_in_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .push            (in_valid & ~in_full),
        .din             (in_element),
        .pop             (elem_stream.valid & elem_stream.ready),
        .dout            (elem_stream.element),
        .empty           (in_empty),
        .full            (in_full),
        .prog_full       ()
    );

    // ----------------------------------------------------------
    // Kernel and control
    // ----------------------------------------------------------
    rw_gen_kernel i_kernel (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .elem_stream     (elem_stream.sink),
        .pop_enable      (pop_enable),
        .job             (job),
        .accept          (accept),
        .req_push        (req_push),
        .req_packet      (req_packet)
    );

    // Fixed two-stage pipe, so stage valids are accept delayed once and req_push
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            accept_q <= 1'b0;
        end else begin
            accept_q <= accept;
        end
    end

    assign kernel_idle = ~accept_q & ~req_push;

    rw_gen_control i_control (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .start           (start),
        .cfg             (cfg),
        .accept          (accept),
        .req_fire        (req_fire),
        .resp_valid      (resp_valid),
        .req_prog_full   (req_prog_full),
        .req_empty       (req_empty),
        .in_empty        (in_empty),
        .kernel_idle     (kernel_idle),
        .job             (job),
        .pop_enable      (pop_enable),
        .done            (done)
    );

    // ----------------------------------------------------------
    // Request FIFO
    // ----------------------------------------------------------
    assign req_valid = ~req_empty;
    assign req_fire  = req_valid & req_ready;

    rw_gen_fifo #(
        .WIDTH      ($bits(mem_request_t)),
        .DEPTH      (FIFO_DEPTH),
        .PROG_THRESH(PROG_FULL_THRESH)
    ) i_req_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .push            (req_push),
        .din             (req_packet),
        .pop             (req_fire),
        .dout            (req_head),
        .empty           (req_empty),
        .full            (),
        .prog_full       (req_prog_full)
    );

    assign req_opcode  = req_head.opcode;
    assign req_address = req_head.address;
    assign req_data    = req_head.data;
    assign req_seq     = req_head.seq;

endmodule : rw_gen_top

/* verification/rw_gen_properties.sv */
/*
 * Concurrent assertions for the read/write generator top level
 * Reset state, start handling, pause, request FIFO and done rules
 */
`timescale 1ns/1ps

module rw_gen_properties
    import rw_gen_ctrl_pkg::*;
    import rw_gen_types_pkg::*;
(
    input logic          ap_clk,
    input logic          areset_generator,
    input logic          start,
    input logic          done,
    input logic          req_valid,
    input logic          req_ready,
    input addr_t         req_address,
    input data_t         req_data,
    input logic          req_push,
    input logic          req_full,
    input logic          req_prog_full,
    input logic          in_ready,
    input logic          accept,
    input job_config_t   job,
    input count_t        outstanding
);

    // Number of assertion failures so far
    int violations = 0;

    // Idle and empty one edge after the registered reset
    a_reset_state: assert property (@(posedge ap_clk)
        areset_generator |=> (done && !req_valid && in_ready))
        else begin
            violations++;
            $error("Outputs not at reset values after reset");
        end

    a_done_falls: assert property (@(posedge ap_clk) disable iff (areset_generator)
        (start && done) |=> !done)
        else begin
            violations++;
            $error("done did not fall after an accepted start");
        end

    // Start during a job leaves the latched job alone
    a_job_held: assert property (@(posedge ap_clk) disable iff (areset_generator)
        (start && !done) |=> $stable(job))
        else begin
            violations++;
            $error("Job changed by a start while busy");
        end

    // Pops stop one edge after the request FIFO reaches its threshold
    a_pause_on_prog_full: assert property (@(posedge ap_clk) disable iff (areset_generator)
        req_prog_full |=> !accept)
        else begin
            violations++;
            $error("Element popped with the request FIFO at its threshold");
        end

    // Threshold must keep room for the kernel stages
    a_req_no_overflow: assert property (@(posedge ap_clk) disable iff (areset_generator)
        req_push |-> !req_full)
        else begin
            violations++;
            $error("Push into a full request FIFO");
        end

    a_req_hold: assert property (@(posedge ap_clk) disable iff (areset_generator)
        (req_valid && !req_ready) |=>
            (req_valid && $stable(req_address) && $stable(req_data)))
        else begin
            violations++;
            $error("Request changed before it was taken");
        end

    a_done_counter: assert property (@(posedge ap_clk) disable iff (areset_generator)
        $rose(done) |-> (!job.wait_responses || (outstanding == '0)))
        else begin
            violations++;
            $error("done rose with responses outstanding");
        end

endmodule : rw_gen_properties

/* verification/rw_gen_tb.sv */
/*
 * Testbench for the read/write generator
 * Clock, reset, element and response stimulus, request model, timeout
 */
`timescale 1ns/1ps

module rw_gen_tb
    import rw_gen_ctrl_pkg::*;
    import rw_gen_types_pkg::*;
();

    // Three jobs of 20, 40 and 24 elements
    localparam int TOTAL_ELEMENTS = 84;
    localparam int CYCLE_LIMIT    = TOTAL_ELEMENTS * 10 + 400;
    localparam int EXP_DEPTH      = 128;

    logic       ap_clk;
    logic       areset;
    logic       start;
    rw_opcode_e cfg_opcode;
    addr_t      cfg_base_address;
    addr_t      cfg_stride;
    count_t     cfg_count;
    logic       cfg_wait_responses;
    logic       in_valid;
    data_t      in_data;
    seq_t       in_seq;
    logic       in_ready;
    logic       req_valid;
    logic       req_ready = 1'b0;
    rw_opcode_e req_opcode;
    addr_t      req_address;
    data_t      req_data;
    seq_t       req_seq;
    logic       resp_valid = 1'b0;
    logic       done;

    // Expected requests in input order
    mem_request_t expected [EXP_DEPTH];
    int           exp_wr = 0;
    int           exp_rd = 0;
    int           fires_seen = 0;
    int           resp_sent = 0;
    int           fires_at_start = 0;
    int           cycles = 0;
    logic         stall_ready = 1'b0;
    logic         resp_enable = 1'b1;
    rw_opcode_e   job_opcode;
    addr_t        job_base;
    addr_t        job_stride;
    int           job_count;
    logic         job_wait;

    rw_gen_top i_dut (.*);

    bind rw_gen_top rw_gen_properties i_props (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .start           (start),
        .done            (done),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .req_address     (req_address),
        .req_data        (req_data),
        .req_push        (req_push),
        .req_full        (i_req_fifo.full),
        .req_prog_full   (req_prog_full),
        .in_ready        (in_ready),
        .accept          (accept),
        .job             (job),
        .outstanding     (i_control.outstanding)
    );

    initial begin
        ap_clk = 1'b0;
        forever #4 ap_clk = ~ap_clk;
    end

    // ----------------------------------------------------------
    // Checks and failure exit
    // ----------------------------------------------------------
    task automatic end_in_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_equal(string what, logic [31:0] got, logic [31:0] want);
        assert (got === want) else begin
            $display("** Error at %0t ns: %s is 0x%08h, expected 0x%08h",
                     $time, what, got, want);
            end_in_failure();
        end
    endtask

    // Request leaves on a rising edge with valid and ready high
    always @(posedge ap_clk) begin
        if (req_valid === 1'b1 && req_ready === 1'b1) begin
            if (exp_rd == exp_wr) begin
                $display("Failure at %0t ns: request left with no element behind it", $time);
                end_in_failure();
            end else begin
                check_equal("req_opcode", 32'(req_opcode), 32'(expected[exp_rd].opcode));
                check_equal("req_address", req_address, expected[exp_rd].address);
                check_equal("req_data", req_data, expected[exp_rd].data);
                check_equal("req_seq", 32'(req_seq), 32'(expected[exp_rd].seq));
                exp_rd = exp_rd + 1;
                fires_seen = fires_seen + 1;
            end
        end
    end

    always @(posedge ap_clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            end_in_failure();
        end
    end

    always @(negedge ap_clk) begin
        if (i_dut.i_props.violations != 0) begin
            $display("Failure at %0t ns: a bound property of the DUT failed", $time);
            end_in_failure();
        end
    end

    // ----------------------------------------------------------
    // Memory side
    // ----------------------------------------------------------
    always @(negedge ap_clk) begin
        if (stall_ready) begin
            req_ready = 1'b0;
        end else begin
            req_ready = ($urandom_range(3) != 0);
        end
    end

    // One response per request and never ahead of it
    always @(negedge ap_clk) begin
        resp_valid = 1'b0;
        if (resp_enable && (fires_seen > resp_sent) && ($urandom_range(1) == 0)) begin
            resp_valid = 1'b1;
            resp_sent = resp_sent + 1;
        end
    end

    // ----------------------------------------------------------
    // Stimulus tasks entered on a falling edge
    // ----------------------------------------------------------
    task automatic apply_reset();
        areset = 1'b1;
        repeat (8) @(negedge ap_clk);
        areset = 1'b0;
        // DUT registers the reset once more
        repeat (2) @(negedge ap_clk);
        check_equal("done after reset", 32'(done), 32'd1);
        check_equal("req_valid after reset", 32'(req_valid), 32'd0);
        check_equal("in_ready after reset", 32'(in_ready), 32'd1);
    endtask

    task automatic launch_job(rw_opcode_e opcode, addr_t base, addr_t stride, int count,
                              logic wait_resp);
        check_equal("done before start", 32'(done), 32'd1);
        job_opcode = opcode;
        job_base = base;
        job_stride = stride;
        job_count = count;
        job_wait = wait_resp;
        fires_at_start = fires_seen;
        cfg_opcode = opcode;
        cfg_base_address = base;
        cfg_stride = stride;
        cfg_count = count_t'(count);
        cfg_wait_responses = wait_resp;
        start = 1'b1;
        @(negedge ap_clk);
        start = 1'b0;
        check_equal("done one cycle after start", 32'(done), 32'd0);
    endtask

    task automatic feed_elements(int n);
        mem_request_t item;
        for (int i = 0; i < n; i++) begin
            if ($urandom_range(4) == 0) begin
                in_valid = 1'b0;
                @(negedge ap_clk);
            end
            in_data = $urandom();
            in_seq = seq_t'($urandom());
            in_valid = 1'b1;
            while (!in_ready) @(negedge ap_clk);
            // Element i of the job is taken on the coming rising edge
            item.opcode = job_opcode;
            item.address = job_base + addr_t'(i) * job_stride;
            item.data = in_data;
            item.seq = in_seq;
            expected[exp_wr] = item;
            exp_wr = exp_wr + 1;
            @(negedge ap_clk);
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_for_done();
        while (!done) @(negedge ap_clk);
        check_equal("requests still unmatched", exp_wr - exp_rd, 0);
        check_equal("requests sent for the job", fires_seen - fires_at_start, job_count);
        check_equal("req_valid at done", 32'(req_valid), 32'd0);
        if (job_wait) begin
            check_equal("responses at done", resp_sent, fires_seen);
        end
    endtask

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        void'($urandom(38));
        areset = 1'b1;
        start = 1'b0;
        cfg_opcode = RW_OP_READ;
        cfg_base_address = '0;
        cfg_stride = '0;
        cfg_count = '0;
        cfg_wait_responses = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        in_seq = '0;
        apply_reset();

        // Write job with full range base and stride so the address wraps
        launch_job(RW_OP_WRITE, $urandom(), $urandom(), 20, 1'b0);
        feed_elements(20);
        wait_for_done();

        // Read job against a stalled memory side
        @(posedge ap_clk);
        stall_ready = 1'b1;
        @(negedge ap_clk);
        launch_job(RW_OP_READ, $urandom() & 32'hffff_fffc, 32'd4, 40, 1'b0);
        fork
            feed_elements(40);
            begin
                while (in_ready) @(negedge ap_clk);
                repeat (6) @(negedge ap_clk);
                check_equal("in_ready while stalled", 32'(in_ready), 32'd0);
                check_equal("req_valid while stalled", 32'(req_valid), 32'd1);
                cfg_opcode = RW_OP_WRITE;
                cfg_base_address = 32'h0000_1000;
                cfg_count = 16'd3;
                start = 1'b1;
                @(negedge ap_clk);
                start = 1'b0;
                check_equal("done after start while busy", 32'(done), 32'd0);
                @(posedge ap_clk);
                stall_ready = 1'b0;
            end
        join
        wait_for_done();

        // Job that waits for every response
        @(posedge ap_clk);
        resp_enable = 1'b0;
        @(negedge ap_clk);
        launch_job(RW_OP_WRITE, $urandom() & 32'hffff_fff0, 32'd16, 24, 1'b1);
        feed_elements(24);
        while (fires_seen - fires_at_start < 24) @(negedge ap_clk);
        repeat (8) begin
            @(negedge ap_clk);
            check_equal("done with responses missing", 32'(done), 32'd0);
        end
        @(posedge ap_clk);
        resp_enable = 1'b1;
        @(negedge ap_clk);
        wait_for_done();

        repeat (4) @(negedge ap_clk);
        if (i_dut.i_props.violations == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "Bound properties of the DUT failed");
        end
    end

endmodule : rw_gen_tb

/* rw_gen_top.f */
verilog/rw_gen_ctrl_pkg.sv
verilog/rw_gen_types_pkg.sv
verilog/rw_gen_stream_if.sv
verilog/rw_gen_fifo.sv
verilog/rw_gen_kernel.sv
verilog/rw_gen_control.sv
verilog/rw_gen_top.sv
verification/rw_gen_properties.sv
verification/rw_gen_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the read/write generator testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module rw_gen_tb -f rw_gen_top.f -Mdir obj_dir -o rw_gen_sim

# Keep running past a property error so the testbench reports it
./obj_dir/rw_gen_sim +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi

echo "Simulation finished without failures"
